/* verilog/tagAccessConsts.svh */
////////////////////
// Tag access constants
// Widths, MSHR count and address slicing for the tag-access stage
////////////////////

`ifndef TAG_ACCESS_CONSTS_SVH
`define TAG_ACCESS_CONSTS_SVH

// Datapath widths
`define ADDR_WIDTH 32
`define DATA_WIDTH 32

// Miss-status holding registers
`define MSHR_NUM 4
`define MSHR_ID_WIDTH 2

// Active list pointer
`define AL_PTR_WIDTH 5

// Cache line offset and the index part seen by the replay queue
`define LINE_BYTE_BITS 4
`define INDEX_SUBSET_BITS 3

`endif

/* verilog/tagAccessPkg.sv */
////////////////////
// Tag access types
// Op kinds, execution states and lane payloads
////////////////////

`include "tagAccessConsts.svh"

`default_nettype none

package tagAccessPkg;

    typedef enum logic [2:0] {
        memLoad, memStore, memEnv, memFence, memOther
    } memOpT;

    typedef enum logic [3:0] {
        notFinished, success, refetchThis, refetchNext,
        trapEbreak, trapEcall, trapMret,
        faultInsnIllegal, faultInsnViolation,
        faultLoadViolation, faultLoadMisaligned,
        faultStoreViolation, faultStoreMisaligned
    } execStateT;

    typedef enum logic [2:0] {
        envBreak, envCall, envMret, envIllegal, envViolation
    } envCodeT;

    typedef enum logic [1:0] {
        sizeByte, sizeHalf, sizeWord
    } accessSizeT;

    typedef struct packed {
        memOpT                     opKind;
        logic                      regValid;
        logic [`ADDR_WIDTH-1:0]    addr;
        logic                      mapIllegal;
        accessSizeT                size;
        envCodeT                   envCode;
        logic                      isFenceI;
        logic [`AL_PTR_WIDTH-1:0]  alPtr;
        logic                      hasAllocatedMshr;
        logic [`MSHR_ID_WIDTH-1:0] mshrId;
    } loadPayloadT;

    typedef struct packed {
        memOpT                    opKind;
        logic                     regValid;
        logic [`ADDR_WIDTH-1:0]   addr;
        logic [`DATA_WIDTH-1:0]   data;
        logic                     mapIllegal;
        accessSizeT               size;
        logic [`AL_PTR_WIDTH-1:0] alPtr;
    } storePayloadT;

    // Half and word accesses must sit on their natural boundary
    function automatic logic isMisaligned(input logic [`ADDR_WIDTH-1:0] addr,
                                          input accessSizeT size);
        return ((size == sizeHalf) && addr[0]) || ((size == sizeWord) && (addr[1:0] != 2'b00));
    endfunction

endpackage

`default_nettype wire

/* verilog/laneRegister.sv */
////////////////////
// Lane register
// Holds one issued memory op and its valid bit between stages
////////////////////

`default_nettype none

module laneRegister #(
    parameter type payloadT = logic
) (
    input  logic    clk,
    input  logic    rstN,
    input  logic    stall,
    input  logic    inValid,
    input  payloadT inPayload,
    output logic    valid,
    output payloadT payload
);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            valid <= 1'b0;
        end else if (!stall) begin
            valid <= inValid;
        end
    end

    // Op fields only matter while valid is set
    always_ff @(posedge clk) begin
        if (!stall) begin
            payload <= inPayload;
        end
    end

    validKnown: assert property (@(posedge clk) disable iff (!rstN) !$isunknown(valid));

endmodule

`default_nettype wire

/* verilog/stageControl.sv */
////////////////////
// Stage control
// Stall, clear and selective flush for both lanes
////////////////////

`include "tagAccessConsts.svh"

`default_nettype none

module stageControl (
    input  logic                     stall,
    input  logic                     clear,
    input  logic                     flushActive,
    input  logic                     flushAll,
    input  logic [`AL_PTR_WIDTH-1:0] flushHead,
    input  logic [`AL_PTR_WIDTH-1:0] flushTail,
    input  logic                     ldValid,
    input  logic [`AL_PTR_WIDTH-1:0] ldAlPtr,
    input  logic                     stValid,
    input  logic [`AL_PTR_WIDTH-1:0] stAlPtr,
    output logic                     ldFlush,
    output logic                     ldUpdate,
    output logic                     ldNextValid,
    output logic                     stFlush,
    output logic                     stUpdate,
    output logic                     stNextValid
);

    // Inclusive circular range from head to tail in the active list
    function automatic logic isFlushed(input logic active,
                                       input logic all,
                                       input logic [`AL_PTR_WIDTH-1:0] head,
                                       input logic [`AL_PTR_WIDTH-1:0] tail,
                                       input logic [`AL_PTR_WIDTH-1:0] ptr);
        logic inRange;
        if (head <= tail) begin
            inRange = (ptr >= head) && (ptr <= tail);
        end else begin
            // Range wraps past the end of the list
            inRange = (ptr >= head) || (ptr <= tail);
        end
        return active && (all || inRange);
    endfunction

    always_comb begin
        ldFlush = isFlushed(flushActive, flushAll, flushHead, flushTail, ldAlPtr);
        stFlush = isFlushed(flushActive, flushAll, flushHead, flushTail, stAlPtr);

        ldUpdate    = ldValid && !stall && !clear && !ldFlush;
        stUpdate    = stValid && !stall && !clear && !stFlush;
        ldNextValid = ldUpdate;
        stNextValid = stUpdate;

        // Full flush must reach every live op in the stage
        if (flushActive && flushAll && (ldValid || stValid)) begin
            assert ((!ldValid || ldFlush) && (!stValid || stFlush))
                else $error("full flush left a valid lane alive");
        end
    end

endmodule

`default_nettype wire

/* verilog/loadResolve.sv */
////////////////////
// Load lane resolve
// Result validity, execution state, replay record and MSHR release
////////////////////

`include "tagAccessConsts.svh"

`default_nettype none

module loadResolve import tagAccessPkg::*; (
    input  logic                          ldValid,
    input  logic                          ldUpdate,
    input  logic                          ldFlush,
    input  loadPayloadT                   payload,
    input  logic                          storeLoadForwarded,
    input  logic                          forwardMiss,
    input  logic                          dcReadHit,
    input  logic                          mshrReadHit,
    input  logic                          mshrAddrHit,
    input  logic [`MSHR_ID_WIDTH-1:0]     mshrAddrHitId,
    input  logic                          loadHasAllocatedMshr,
    input  logic [`MSHR_ID_WIDTH-1:0]     loadMshrId,
    output logic                          executeLoad,
    output logic [`ADDR_WIDTH-1:0]        executedLoadAddr,
    output logic                          ldRegValid,
    output execStateT                     ldExecState,
    output logic                          ldReplay,
    output logic [`MSHR_ID_WIDTH-1:0]     ldReplayMshrId,
    output logic                          ldReplayAddrHit,
    output logic [`INDEX_SUBSET_BITS-1:0] ldReplayAddrSubset,
    output logic [`MSHR_NUM-1:0]          mshrRelease
);

    logic                      isLoad;
    logic                      allocated;
    logic [`MSHR_ID_WIDTH-1:0] mshrId;
    logic                      regValid;
    execStateT                 state;

    always_comb begin
        isLoad    = (payload.opKind == memLoad);
        allocated = payload.hasAllocatedMshr || loadHasAllocatedMshr;

        // MSHR id recorded for the replay queue
        if (payload.hasAllocatedMshr) begin
            mshrId = payload.mshrId;
        end else if (loadHasAllocatedMshr) begin
            mshrId = loadMshrId;
        end else begin
            mshrId = mshrAddrHitId;
        end

        regValid = payload.regValid;
        state    = success;
        if (isLoad) begin
            if (storeLoadForwarded) begin
                regValid = payload.regValid && !forwardMiss;
                state    = forwardMiss ? refetchThis : success;
            end else if (allocated) begin
                // Data can only come back through its own MSHR
                regValid = payload.regValid && mshrReadHit;
                state    = mshrReadHit ? success : refetchThis;
            end else if (mshrReadHit) begin
                state = success;
            end else begin
                regValid = payload.regValid && dcReadHit;
                state    = dcReadHit ? success : refetchThis;
            end
        end else if (payload.opKind == memEnv) begin
            case (payload.envCode)
                envBreak:     state = trapEbreak;
                envCall:      state = trapEcall;
                envMret:      state = trapMret;
                envIllegal:   state = faultInsnIllegal;
                envViolation: state = faultInsnViolation;
                default:      state = trapEbreak;
            endcase
        end else if ((payload.opKind == memFence) && payload.isFenceI) begin
            // Later fetches may hold stale instruction cache lines
            state = refetchNext;
        end

        // Access faults take over from a finished load
        if (isLoad && (state inside {success, refetchNext})) begin
            if (payload.mapIllegal) begin
                state = faultLoadViolation;
            end else if (isMisaligned(payload.addr, payload.size)) begin
                state = faultLoadMisaligned;
            end
        end
        if (!ldUpdate || !payload.regValid) begin
            state = notFinished;
        end

        // Free the MSHR of a load that will never read it
        mshrRelease = '0;
        if (isLoad && allocated &&
            ((ldUpdate && storeLoadForwarded) || (ldValid && ldFlush))) begin
            mshrRelease[mshrId] = 1'b1;
        end
        assert ($onehot0(mshrRelease)) else $error("more than one MSHR released");
    end

    assign executeLoad        = ldUpdate && isLoad;
    assign executedLoadAddr   = payload.addr;
    assign ldRegValid         = regValid;
    assign ldExecState        = state;
    assign ldReplay           = ldUpdate && !regValid;
    assign ldReplayMshrId     = mshrId;
    assign ldReplayAddrHit    = mshrAddrHit;
    assign ldReplayAddrSubset = payload.addr[`LINE_BYTE_BITS +: `INDEX_SUBSET_BITS];

endmodule

`default_nettype wire

/* verilog/storeResolve.sv */
////////////////////
// Store lane resolve
// Execution state, order violation and replay record of a store
////////////////////

`include "tagAccessConsts.svh"

`default_nettype none

module storeResolve import tagAccessPkg::*; (
    input  logic                          stUpdate,
    input  storePayloadT                  payload,
    input  logic                          storeConflict,
    output logic                          executeStore,
    output logic [`ADDR_WIDTH-1:0]        executedStoreAddr,
    output logic [`DATA_WIDTH-1:0]        executedStoreData,
    output logic                          stRegValid,
    output execStateT                     stExecState,
    output logic                          storeOrderViolation,
    output logic                          stReplay,
    output logic [`INDEX_SUBSET_BITS-1:0] stReplayAddrSubset
);

    logic isStore;

    always_comb begin
        isStore = (payload.opKind == memStore);

        // A younger load already read stale data, so restart after this store
        storeOrderViolation = stUpdate && payload.regValid && isStore && storeConflict;
        stExecState = storeOrderViolation ? refetchNext : success;

        if (isStore) begin
            if (payload.mapIllegal) begin
                stExecState = faultStoreViolation;
            end else if (isMisaligned(payload.addr, payload.size)) begin
                stExecState = faultStoreMisaligned;
            end
        end
        if (!stUpdate || !payload.regValid) begin
            stExecState = notFinished;
        end
    end

    assign executeStore       = stUpdate && isStore;
    assign executedStoreAddr  = payload.addr;
    assign executedStoreData  = payload.data;
    assign stRegValid         = payload.regValid;
    assign stReplay           = stUpdate && !payload.regValid;
    assign stReplayAddrSubset = payload.addr[`LINE_BYTE_BITS +: `INDEX_SUBSET_BITS];

endmodule

`default_nettype wire

/* verilog/tagAccessStage.sv */
////////////////////
// Memory tag access stage
// One load and one store lane between execute and memory access
////////////////////

`include "tagAccessConsts.svh"

`default_nettype none

module tagAccessStage import tagAccessPkg::*; (
    input  logic                          clk,
    input  logic                          rstN,
    input  logic                          stall,
    input  logic                          clear,
    input  logic                          flushActive,
    input  logic                          flushAll,
    input  logic [`AL_PTR_WIDTH-1:0]      flushHead,
    input  logic [`AL_PTR_WIDTH-1:0]      flushTail,
    input  logic                          ldInValid,
    input  loadPayloadT                   ldIn,
    input  logic                          stInValid,
    input  storePayloadT                  stIn,
    input  logic                          storeLoadForwarded,
    input  logic                          forwardMiss,
    input  logic                          dcReadHit,
    input  logic                          mshrReadHit,
    input  logic                          mshrAddrHit,
    input  logic [`MSHR_ID_WIDTH-1:0]     mshrAddrHitId,
    input  logic                          loadHasAllocatedMshr,
    input  logic [`MSHR_ID_WIDTH-1:0]     loadMshrId,
    input  logic                          storeConflict,
    output logic                          executeLoad,
    output logic [`ADDR_WIDTH-1:0]        executedLoadAddr,
    output logic                          executeStore,
    output logic [`ADDR_WIDTH-1:0]        executedStoreAddr,
    output logic [`DATA_WIDTH-1:0]        executedStoreData,
    output logic                          storeOrderViolation,
    output logic [`MSHR_NUM-1:0]          mshrRelease,
    output logic                          ldReplay,
    output logic [`MSHR_ID_WIDTH-1:0]     ldReplayMshrId,
    output logic                          ldReplayAddrHit,
    output logic [`INDEX_SUBSET_BITS-1:0] ldReplayAddrSubset,
    output logic                          stReplay,
    output logic [`INDEX_SUBSET_BITS-1:0] stReplayAddrSubset,
    output logic                          ldOutValid,
    output logic                          ldRegValid,
    output execStateT                     ldExecState,
    output logic                          stOutValid,
    output logic                          stRegValid,
    output execStateT                     stExecState
);

    logic         ldValid, stValid, ldFlush, ldUpdate, stUpdate;
    loadPayloadT  ldPayload;
    storePayloadT stPayload;

    laneRegister #(.payloadT(loadPayloadT)) ldReg (
        .clk, .rstN, .stall, .inValid(ldInValid), .inPayload(ldIn),
        .valid(ldValid), .payload(ldPayload)
    );

    laneRegister #(.payloadT(storePayloadT)) stReg (
        .clk, .rstN, .stall, .inValid(stInValid), .inPayload(stIn),
        .valid(stValid), .payload(stPayload)
    );

    // Store flush only gates the update, so its flag is left open
    stageControl control (
        .stall, .clear, .flushActive, .flushAll, .flushHead, .flushTail,
        .ldValid, .ldAlPtr(ldPayload.alPtr), .stValid, .stAlPtr(stPayload.alPtr),
        .ldFlush, .ldUpdate, .ldNextValid(ldOutValid),
        .stFlush(), .stUpdate, .stNextValid(stOutValid)
    );

    loadResolve ldResolve (
        .ldValid, .ldUpdate, .ldFlush, .payload(ldPayload),
        .storeLoadForwarded, .forwardMiss, .dcReadHit, .mshrReadHit,
        .mshrAddrHit, .mshrAddrHitId, .loadHasAllocatedMshr, .loadMshrId,
        .executeLoad, .executedLoadAddr, .ldRegValid, .ldExecState,
        .ldReplay, .ldReplayMshrId, .ldReplayAddrHit, .ldReplayAddrSubset, .mshrRelease
    );

    storeResolve stResolve (
        .stUpdate, .payload(stPayload), .storeConflict,
        .executeStore, .executedStoreAddr, .executedStoreData, .stRegValid, .stExecState,
        .storeOrderViolation, .stReplay, .stReplayAddrSubset
    );

endmodule

`default_nettype wire

/* tests/tagAccessTests.svh */
////////////////////
// Tag access stage tests
// Directed tasks for reset, stall, loads, faults, stores and flush
////////////////////

task automatic resetAndStallTest();
    loadPayloadT ld;
    loadPayloadT other;
    #1;
    checkValue("ldOutValid", 64'(ldOutValid), 64'(0));
    checkValue("stOutValid", 64'(stOutValid), 64'(0));
    checkValue("executeLoad", 64'(executeLoad), 64'(0));
    checkValue("executeStore", 64'(executeStore), 64'(0));
    checkValue("ldReplay", 64'(ldReplay), 64'(0));
    checkValue("stReplay", 64'(stReplay), 64'(0));
    checkValue("storeOrderViolation", 64'(storeOrderViolation), 64'(0));
    checkValue("mshrRelease", 64'(mshrRelease), 64'(0));
    ld = makeLoad(randomWordAddr());
    other = makeLoad(randomWordAddr());
    issueOps(1'b1, ld, 1'b0, '0);
    stall = 1'b1;
    dcReadHit = 1'b1;
    // A younger op waits at the input while the stage is held
    ldInValid = 1'b1;
    ldIn = other;
    repeat (2) begin
        #1;
        checkValue("executeLoad", 64'(executeLoad), 64'(0));
        checkValue("ldOutValid", 64'(ldOutValid), 64'(0));
        checkValue("ldReplay", 64'(ldReplay), 64'(0));
        checkValue("ldExecState", 64'(ldExecState), 64'(notFinished));
        @(negedge clk);
    end
    ldInValid = 1'b0;
    stall = 1'b0;
    #1;
    checkValue("executeLoad", 64'(executeLoad), 64'(1));
    checkValue("executedLoadAddr", 64'(executedLoadAddr), 64'(ld.addr));
    checkValue("ldExecState", 64'(ldExecState), 64'(success));
endtask

task automatic loadCase(input logic fwd, input logic fwdMiss, input logic dcHit,
                        input logic mshrHit, input execStateT expState);
    loadPayloadT ld;
    logic expValid;
    logic [31:0] hitBits;
    ld = makeLoad(randomWordAddr());
    hitBits = randomWord();
    expValid = (expState == success);
    issueOps(1'b1, ld, 1'b0, '0);
    storeLoadForwarded = fwd;
    forwardMiss = fwdMiss;
    dcReadHit = dcHit;
    mshrReadHit = mshrHit;
    // No MSHR allocated, so the replay id comes from the address hit
    mshrAddrHit = hitBits[2];
    mshrAddrHitId = hitBits[1:0];
    #1;
    checkValue("ldExecState", 64'(ldExecState), 64'(expState));
    checkValue("ldRegValid", 64'(ldRegValid), 64'(expValid));
    checkValue("ldReplay", 64'(ldReplay), 64'(!expValid));
    checkValue("executeLoad", 64'(executeLoad), 64'(1));
    checkValue("executedLoadAddr", 64'(executedLoadAddr), 64'(ld.addr));
    checkValue("ldReplayAddrSubset", 64'(ldReplayAddrSubset), 64'(ld.addr[6:4]));
    checkValue("ldReplayAddrHit", 64'(ldReplayAddrHit), 64'(hitBits[2]));
    checkValue("ldReplayMshrId", 64'(ldReplayMshrId), 64'(hitBits[1:0]));
endtask

task automatic loadResolutionTest();
    loadCase(1'b0, 1'b0, 1'b1, 1'b0, success);
    loadCase(1'b0, 1'b0, 1'b0, 1'b0, refetchThis);
    loadCase(1'b0, 1'b0, 1'b0, 1'b1, success);
    loadCase(1'b1, 1'b0, 1'b0, 1'b0, success);
    loadCase(1'b1, 1'b1, 1'b0, 1'b0, refetchThis);
endtask

task automatic faultTest();
    loadPayloadT ld;
    storePayloadT st;
    ld = makeLoad(randomWordAddr());
    ld.mapIllegal = 1'b1;
    st = makeStore(randomWordAddr(), randomWord());
    st.mapIllegal = 1'b1;
    issueOps(1'b1, ld, 1'b1, st);
    dcReadHit = 1'b1;
    #1;
    checkValue("ldExecState", 64'(ldExecState), 64'(faultLoadViolation));
    checkValue("stExecState", 64'(stExecState), 64'(faultStoreViolation));
    // Word load on a half boundary, half store on an odd byte
    ld = makeLoad(randomWordAddr() | 32'h2);
    st = makeStore(randomWordAddr() | 32'h1, randomWord());
    st.size = sizeHalf;
    issueOps(1'b1, ld, 1'b1, st);
    dcReadHit = 1'b1;
    #1;
    checkValue("ldExecState", 64'(ldExecState), 64'(faultLoadMisaligned));
    checkValue("stExecState", 64'(stExecState), 64'(faultStoreMisaligned));
endtask

task automatic envFenceTest();
    envCodeT codes [5];
    execStateT expected [5];
    loadPayloadT op;
    codes = '{envBreak, envCall, envMret, envIllegal, envViolation};
    expected = '{trapEbreak, trapEcall, trapMret, faultInsnIllegal, faultInsnViolation};
    for (int i = 0; i < 5; i++) begin
        op = makeLoad(randomWordAddr());
        op.opKind = memEnv;
        op.envCode = codes[i];
        issueOps(1'b1, op, 1'b0, '0);
        #1;
        checkValue("ldExecState", 64'(ldExecState), 64'(expected[i]));
        checkValue("executeLoad", 64'(executeLoad), 64'(0));
    end
    op = makeLoad(randomWordAddr());
    op.opKind = memFence;
    op.isFenceI = 1'b1;
    issueOps(1'b1, op, 1'b0, '0);
    #1;
    checkValue("ldExecState", 64'(ldExecState), 64'(refetchNext));
    checkValue("ldOutValid", 64'(ldOutValid), 64'(1));
endtask

task automatic storeConflictTest();
    storePayloadT st;
    st = makeStore(randomWordAddr(), randomWord());
    issueOps(1'b0, '0, 1'b1, st);
    storeConflict = 1'b1;
    #1;
    checkValue("stExecState", 64'(stExecState), 64'(refetchNext));
    checkValue("storeOrderViolation", 64'(storeOrderViolation), 64'(1));
    st = makeStore(randomWordAddr(), randomWord());
    issueOps(1'b0, '0, 1'b1, st);
    #1;
    checkValue("stExecState", 64'(stExecState), 64'(success));
    checkValue("storeOrderViolation", 64'(storeOrderViolation), 64'(0));
    checkValue("executeStore", 64'(executeStore), 64'(1));
    checkValue("executedStoreAddr", 64'(executedStoreAddr), 64'(st.addr));
    checkValue("executedStoreData", 64'(executedStoreData), 64'(st.data));
    checkValue("stRegValid", 64'(stRegValid), 64'(1));
    checkValue("stReplay", 64'(stReplay), 64'(0));
    checkValue("stReplayAddrSubset", 64'(stReplayAddrSubset), 64'(st.addr[6:4]));
    // Store whose source register is not ready goes to the replay queue
    st = makeStore(randomWordAddr(), randomWord());
    st.regValid = 1'b0;
    issueOps(1'b0, '0, 1'b1, st);
    #1;
    checkValue("stReplay", 64'(stReplay), 64'(1));
    checkValue("stRegValid", 64'(stRegValid), 64'(0));
    checkValue("stExecState", 64'(stExecState), 64'(notFinished));
endtask

task automatic flushCase(input logic [4:0] head, input logic [4:0] tail, input logic [4:0] ptr,
                         input logic all, input logic expFlushed);
    loadPayloadT ld;
    storePayloadT st;
    logic [3:0] expRelease;
    logic [31:0] idBits;
    ld = makeLoad(randomWordAddr());
    ld.alPtr = ptr;
    ld.hasAllocatedMshr = 1'b1;
    idBits = randomWord();
    ld.mshrId = idBits[`MSHR_ID_WIDTH-1:0];
    st = makeStore(randomWordAddr(), randomWord());
    st.alPtr = ptr;
    expRelease = 4'b0000;
    if (expFlushed) begin
        expRelease[ld.mshrId] = 1'b1;
    end
    issueOps(1'b1, ld, 1'b1, st);
    mshrReadHit = 1'b1;
    {flushActive, flushAll, flushHead, flushTail} = {1'b1, all, head, tail};
    #1;
    checkValue("ldOutValid", 64'(ldOutValid), 64'(!expFlushed));
    checkValue("stOutValid", 64'(stOutValid), 64'(!expFlushed));
    checkValue("executeLoad", 64'(executeLoad), 64'(!expFlushed));
    checkValue("mshrRelease", 64'(mshrRelease), 64'(expRelease));
    checkValue("ldReplayMshrId", 64'(ldReplayMshrId), 64'(ld.mshrId));
endtask

task automatic flushTest();
    flushCase(5'd4, 5'd10, 5'd7, 1'b0, 1'b1);
    flushCase(5'd4, 5'd10, 5'd12, 1'b0, 1'b0);
    flushCase(5'd4, 5'd10, 5'd4, 1'b0, 1'b1);
    // Range wrapping past the last entry
    flushCase(5'd28, 5'd3, 5'd30, 1'b0, 1'b1);
    flushCase(5'd28, 5'd3, 5'd2, 1'b0, 1'b1);
    flushCase(5'd28, 5'd3, 5'd15, 1'b0, 1'b0);
    flushCase(5'd4, 5'd10, 5'd20, 1'b1, 1'b1);
endtask

/* tests/tagAccessStageTb.sv */
////////////////////
// Tag access stage testbench
// Drives both lanes through directed tests and counts mismatches
////////////////////

`include "tagAccessConsts.svh"

`default_nettype none

module tagAccessStageTb import tagAccessPkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int testCount = 6;

    logic clk, rstN, stall, clear, flushActive, flushAll;
    logic [`AL_PTR_WIDTH-1:0] flushHead, flushTail;
    logic ldInValid, stInValid;
    loadPayloadT ldIn;
    storePayloadT stIn;
    logic storeLoadForwarded, forwardMiss, dcReadHit, mshrReadHit, mshrAddrHit;
    logic loadHasAllocatedMshr, storeConflict;
    logic [`MSHR_ID_WIDTH-1:0] mshrAddrHitId, loadMshrId, ldReplayMshrId;
    logic executeLoad, executeStore, storeOrderViolation, ldReplay, ldReplayAddrHit, stReplay;
    logic ldOutValid, ldRegValid, stOutValid, stRegValid;
    logic [`ADDR_WIDTH-1:0] executedLoadAddr, executedStoreAddr;
    logic [`DATA_WIDTH-1:0] executedStoreData;
    logic [`MSHR_NUM-1:0] mshrRelease;
    logic [`INDEX_SUBSET_BITS-1:0] ldReplayAddrSubset, stReplayAddrSubset;
    execStateT ldExecState, stExecState;
    integer errors, checks, seed;

    tagAccessStage dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic checkValue(input string name, input logic [63:0] actual,
                              input logic [63:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("MISMATCH %s: got 0x%0h, expected 0x%0h at %0t", name, actual, expected,
                     $time);
        end
    endtask

    function automatic logic [31:0] randomWord();
        return $random(seed);
    endfunction

    function automatic logic [`ADDR_WIDTH-1:0] randomWordAddr();
        logic [`ADDR_WIDTH-1:0] addr;
        addr = randomWord();
        addr[1:0] = 2'b00;
        return addr;
    endfunction

    // Plain aligned word load with a valid destination register
    function automatic loadPayloadT makeLoad(input logic [`ADDR_WIDTH-1:0] addr);
        loadPayloadT p;
        p = '0;
        p.opKind = memLoad;
        p.regValid = 1'b1;
        p.addr = addr;
        p.size = sizeWord;
        return p;
    endfunction

    function automatic storePayloadT makeStore(input logic [`ADDR_WIDTH-1:0] addr,
                                               input logic [`DATA_WIDTH-1:0] data);
        storePayloadT p;
        p = '0;
        p.opKind = memStore;
        p.regValid = 1'b1;
        p.addr = addr;
        p.data = data;
        p.size = sizeWord;
        return p;
    endfunction

    task automatic clearAnswers();
        {storeLoadForwarded, forwardMiss, dcReadHit, mshrReadHit} = 4'b0000;
        {mshrAddrHit, loadHasAllocatedMshr, storeConflict} = 3'b000;
        mshrAddrHitId = '0;
        loadMshrId = '0;
        {flushActive, flushAll} = 2'b00;
        flushHead = '0;
        flushTail = '0;
    endtask

    // Offer ops on one falling edge, they are registered by the next one
    task automatic issueOps(input logic ldV, input loadPayloadT ld,
                            input logic stV, input storePayloadT st);
        @(negedge clk);
        clearAnswers();
        ldInValid = ldV;
        ldIn = ld;
        stInValid = stV;
        stIn = st;
        @(negedge clk);
        ldInValid = 1'b0;
        stInValid = 1'b0;
    endtask

    `include "tagAccessTests.svh"

    initial begin
        seed = 32'h8d9448df;
        errors = 0;
        checks = 0;
        rstN = 1'b0;
        stall = 1'b0;
        clear = 1'b0;
        ldInValid = 1'b0;
        stInValid = 1'b0;
        ldIn = '0;
        stIn = '0;
        clearAnswers();
        repeat (3) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;
        resetAndStallTest();
        loadResolutionTest();
        faultTest();
        envFenceTest();
        storeConflictTest();
        flushTest();
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    // Each test needs far fewer than 20 cycles
    initial begin
        repeat (testCount * 20) @(posedge clk);
        $display("Timeout: tests still running after %0d cycles", testCount * 20);
        $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
+incdir+verilog
+incdir+tests
verilog/tagAccessPkg.sv
verilog/laneRegister.sv
verilog/stageControl.sv
verilog/loadResolve.sv
verilog/storeResolve.sv
verilog/tagAccessStage.sv
tests/tagAccessStageTb.sv

/* run.sh */
#!/bin/sh
# Build the tag access stage testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
    -f all.f --top-module tagAccessStageTb -o tagAccessSim

output=$(./obj_dir/tagAccessSim)
echo "$output"

if echo "$output" | grep -qx "Done: no errors"; then
    exit 0
fi
exit 1
